//--- project.f
source/lc_jtag_pkg.sv
source/pinmux_cfg_pkg.sv
source/jtag_if.sv
source/lc_sync.sv
source/strap_sampler.sv
source/tap_mux.sv
source/pinmux_strap_top.sv
tests/strap_checker.sv
tests/tb_pinmux_strap.sv

//--- tests/tb_pinmux_strap.sv
/*
  Testbench for the strap sampling and TAP selection top level, random pads
  and life-cycle enables checked against a cycle model
*/
`timescale 1ns/1ns
`default_nettype none

module tb_pinmux_strap;

  import lc_jtag_pkg::*;
  import pinmux_cfg_pkg::*;

  localparam int unsigned NumRounds = 36;
  localparam int unsigned NumChecks = 12;

  logic              clk_i;
  logic              rst_ni;
  lc_tx_t            scanmode_i;
  lc_tx_t            lc_dft_en_i;
  lc_tx_t            lc_hw_debug_en_i;
  logic              strap_en_i;
  logic [NumIos-1:0] in_padring_i;
  logic [NumIos-1:0] out_core_i;
  logic [NumIos-1:0] oe_core_i;
  logic [NumIos-1:0] out_padring_o;
  logic [NumIos-1:0] oe_padring_o;
  logic [NumIos-1:0] in_core_o;
  logic              dft_strap_valid_o;
  dft_strap_t        dft_strap_o;
  // TAP links, request is {tck, tms, tdi, trst_n}, index 0 lc, 1 rv, 2 dft
  wire  [3:0]        lc_req;
  wire  [3:0]        rv_req;
  wire  [3:0]        dft_req;
  logic [2:0]        tap_tdo;
  logic [2:0]        tap_tdo_oe;

  // Reference model state
  lc_tx_t            m_dbg_s1;
  lc_tx_t            m_dbg_s2;
  lc_tx_t            m_dft_s1;
  lc_tx_t            m_dft_s2;
  logic [1:0]        m_tap;
  dft_strap_t        m_dft;
  logic              m_valid;
  logic              m_cont;
  logic              m_pulse_q;

  logic [31:0]       rng;
  int unsigned       errors;

  pinmux_strap_top dut0 (
    .clk_i (clk_i), .rst_ni (rst_ni), .scanmode_i (scanmode_i),
    .lc_dft_en_i (lc_dft_en_i), .lc_hw_debug_en_i (lc_hw_debug_en_i),
    .strap_en_i (strap_en_i), .in_padring_i (in_padring_i),
    .out_core_i (out_core_i), .oe_core_i (oe_core_i),
    .out_padring_o (out_padring_o), .oe_padring_o (oe_padring_o),
    .in_core_o (in_core_o), .dft_strap_valid_o (dft_strap_valid_o),
    .dft_strap_o (dft_strap_o),
    .lc_tck_o (lc_req[3]), .lc_tms_o (lc_req[2]), .lc_tdi_o (lc_req[1]),
    .lc_trst_no (lc_req[0]), .lc_tdo_i (tap_tdo[0]), .lc_tdo_oe_i (tap_tdo_oe[0]),
    .rv_tck_o (rv_req[3]), .rv_tms_o (rv_req[2]), .rv_tdi_o (rv_req[1]),
    .rv_trst_no (rv_req[0]), .rv_tdo_i (tap_tdo[1]), .rv_tdo_oe_i (tap_tdo_oe[1]),
    .dft_tck_o (dft_req[3]), .dft_tms_o (dft_req[2]), .dft_tdi_o (dft_req[1]),
    .dft_trst_no (dft_req[0]), .dft_tdo_i (tap_tdo[2]), .dft_tdo_oe_i (tap_tdo_oe[2])
  );

  initial clk_i = 1'b0;
  always #20 clk_i = ~clk_i;

  ////////////////////
  // Reference model
  ////////////////////

  always @(posedge clk_i or negedge rst_ni) begin : ref_model
    logic sample;
    if (!rst_ni) begin
      m_dbg_s1  <= lc_off;
      m_dbg_s2  <= lc_off;
      m_dft_s1  <= lc_off;
      m_dft_s2  <= lc_off;
      m_tap     <= 2'b00;
      m_dft     <= 2'b00;
      m_valid   <= 1'b0;
      m_cont    <= 1'b0;
      m_pulse_q <= 1'b0;
    end else begin
      sample = strap_en_i | m_cont;
      // Enables reach the logic two edges late
      m_dbg_s1 <= lc_hw_debug_en_i;
      m_dbg_s2 <= m_dbg_s1;
      m_dft_s1 <= lc_dft_en_i;
      m_dft_s2 <= m_dft_s1;
      if (sample) begin
        m_tap[0] <= in_padring_i[TapStrap0Idx];
      end
      if (sample && m_dbg_s2 == lc_on) begin
        m_tap[1] <= in_padring_i[TapStrap1Idx];
      end
      if (sample && m_dft_s2 == lc_on) begin
        m_dft   <= {in_padring_i[DftStrap1Idx], in_padring_i[DftStrap0Idx]};
        m_valid <= 1'b1;
      end
      m_pulse_q <= strap_en_i;
      if (m_pulse_q && m_dft_s2 == lc_on && m_tap != FuncSel) begin
        m_cont <= 1'b1;
      end
    end
  end

  ////////////////////
  // Helpers
  ////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Any pattern but On counts as off
  function automatic lc_tx_t off_value(input logic [3:0] r);
    return (r == lc_on) ? lc_off : r;
  endfunction

  task automatic check_val(input string name, input logic [31:0] exp,
                           input logic [31:0] act);
    if (exp !== act) begin
      errors++;
      $display("[FAIL] %0t ns %s expected %0h actual %0h", $time, name, exp, act);
    end
  endtask

  task automatic drive_random();
    rng = xorshift32(rng);
    in_padring_i <= rng[15:0];
    out_core_i   <= rng[31:16];
    rng = xorshift32(rng);
    oe_core_i    <= rng[15:0];
    tap_tdo      <= rng[18:16];
    tap_tdo_oe   <= rng[21:19];
  endtask

  task automatic check_outputs();
    logic [1:0]        sel;
    logic [3:0]        req;
    logic [NumIos-1:0] exp_in;
    logic [NumIos-1:0] exp_out;
    logic [NumIos-1:0] exp_oe;
    sel = 2'd0;
    if (m_tap == LcTapSel) begin
      sel = 2'd1;
    end else if (m_tap == RvTapSel && m_dbg_s2 == lc_on) begin
      sel = 2'd2;
    end else if (m_tap == DftTapSel && m_dft_s2 == lc_on) begin
      sel = 2'd3;
    end
    req = {in_padring_i[TckIdx], in_padring_i[TmsIdx], in_padring_i[TdiIdx],
           (scanmode_i == lc_on) ? rst_ni : in_padring_i[TrstIdx]};
    exp_in  = in_padring_i;
    exp_out = out_core_i;
    exp_oe  = oe_core_i;
    if (sel != 2'd0) begin
      exp_in[TckIdx]  = JtagTieOffs[TckIdx];
      exp_in[TmsIdx]  = JtagTieOffs[TmsIdx];
      exp_in[TrstIdx] = JtagTieOffs[TrstIdx];
      exp_in[TdiIdx]  = JtagTieOffs[TdiIdx];
      exp_in[TdoIdx]  = JtagTieOffs[TdoIdx];
      exp_out[TdoIdx] = tap_tdo[sel - 2'd1];
      exp_oe[TdoIdx]  = tap_tdo_oe[sel - 2'd1];
    end
    check_val("lc_req", (sel == 2'd1) ? req : 4'h0, lc_req);
    check_val("rv_req", (sel == 2'd2) ? req : 4'h0, rv_req);
    check_val("dft_req", (sel == 2'd3) ? req : 4'h0, dft_req);
    check_val("in_core_o", exp_in, in_core_o);
    check_val("out_padring_o", exp_out, out_padring_o);
    check_val("oe_padring_o", exp_oe, oe_padring_o);
    check_val("tap_strap", m_tap, dut0.tap_strap);
    check_val("dft_strap_o", m_dft, dft_strap_o);
    check_val("dft_strap_valid_o", m_valid, dft_strap_valid_o);
  endtask

  // DFT rounds only, valid follows the strap pulse
  task automatic wait_valid();
    int unsigned cycles;
    cycles = 0;
    do begin
      @(negedge clk_i);
      cycles++;
    end while (dft_strap_valid_o !== 1'b1 && cycles < 8);
    if (dft_strap_valid_o !== 1'b1) begin
      errors++;
      $display("Timeout: DFT strap valid did not rise after the strap pulse");
    end
    @(posedge clk_i);
  endtask

  // Mode 0 all off, 1 both on, 2 DFT strap gated, 3 debug dropped later,
  // 4 DFT only, 5 both on in scan mode
  task automatic run_round(input int unsigned mode);
    lc_tx_t     dbg;
    lc_tx_t     dft;
    lc_tx_t     scan;
    logic [1:0] strap;
    rng   = xorshift32(rng);
    dbg   = (mode == 1 || mode == 2 || mode == 3 || mode == 5) ? lc_on : off_value(rng[3:0]);
    dft   = (mode == 1 || mode == 4 || mode == 5) ? lc_on : off_value(rng[7:4]);
    scan  = (mode == 5) ? lc_on : off_value(rng[11:8]);
    strap = rng[13:12];
    if (mode == 2) begin
      strap = DftTapSel;
    end
    if (mode == 3) begin
      strap = RvTapSel;
    end
    @(posedge clk_i);
    rst_ni           <= 1'b0;
    lc_hw_debug_en_i <= dbg;
    lc_dft_en_i      <= dft;
    scanmode_i       <= scan;
    strap_en_i       <= 1'b0;
    repeat (16) @(posedge clk_i);
    rst_ni <= 1'b1;
    // Let the synchronizers settle before the pulse
    repeat (4) @(posedge clk_i);
    drive_random();
    in_padring_i[TapStrap0Idx] <= strap[0];
    in_padring_i[TapStrap1Idx] <= strap[1];
    strap_en_i <= 1'b1;
    @(posedge clk_i);
    strap_en_i <= 1'b0;
    if (dft == lc_on) begin
      wait_valid();
    end
    for (int i = 0; i < 2 * NumChecks; i++) begin
      if (mode == 3 && i == NumChecks) begin
        rng = xorshift32(rng);
        lc_hw_debug_en_i <= off_value(rng[3:0]);
      end
      drive_random();
      @(negedge clk_i);
      check_outputs();
      @(posedge clk_i);
    end
  endtask

  ////////////////////
  // Main sequence
  ////////////////////

  initial begin
    rng              = 32'h76fb;
    errors           = 0;
    rst_ni           = 1'b0;
    scanmode_i       = lc_off;
    lc_dft_en_i      = lc_off;
    lc_hw_debug_en_i = lc_off;
    strap_en_i       = 1'b0;
    in_padring_i     = '0;
    out_core_i       = '0;
    oe_core_i        = '0;
    tap_tdo          = '0;
    tap_tdo_oe       = '0;
    for (int r = 0; r < NumRounds; r++) begin
      run_round(r % 6);
    end
    @(negedge clk_i);
    errors += dut0.u_strap_checker.assert_fails;
    $display("Run finished with %0d errors", errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tests/strap_checker.sv
/*
  Bound assertions on the strap pulse, TAP gating and DFT strap valid
*/
`timescale 1ns/1ns
`default_nettype none

module strap_checker (
  input wire logic                clk_i,
  input wire logic                rst_ni,
  input wire logic                strap_en_i,
  input wire lc_jtag_pkg::lc_tx_t hw_debug_en_i,
  input wire lc_jtag_pkg::lc_tx_t dft_en_i,
  input wire logic [3:0]          rv_req_i,
  input wire logic [3:0]          dft_req_i,
  input wire logic                dft_strap_valid_i
);

  import lc_jtag_pkg::*;

  // Failed assertions, read by the testbench at the end of the run
  int unsigned assert_fails = 0;
  logic        strap_seen_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      strap_seen_q <= 1'b0;
    end else if (strap_en_i) begin
      strap_seen_q <= 1'b1;
    end
  end

  a_single_strap: assert property (@(posedge clk_i) disable iff (!rst_ni)
    strap_en_i |-> !strap_seen_q)
    else begin
      $error("strap enable pulsed more than once since reset");
      assert_fails++;
    end

  // Gated TAPs get no request at all
  a_rv_gated: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (hw_debug_en_i != lc_on) |-> (rv_req_i == 4'h0))
    else begin
      $error("RISC-V TAP driven while hardware debug is off");
      assert_fails++;
    end

  a_dft_gated: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (dft_en_i != lc_on) |-> (dft_req_i == 4'h0))
    else begin
      $error("DFT TAP driven while DFT is off");
      assert_fails++;
    end

  a_valid_sticky: assert property (@(posedge clk_i) disable iff (!rst_ni)
    dft_strap_valid_i |=> dft_strap_valid_i)
    else begin
      $error("DFT strap valid fell without a reset");
      assert_fails++;
    end

endmodule

bind pinmux_strap_top strap_checker u_strap_checker (
  .clk_i             (clk_i),
  .rst_ni            (rst_ni),
  .strap_en_i        (strap_en_i),
  .hw_debug_en_i     (lc_hw_debug_en[1]),
  .dft_en_i          (lc_dft_en[1]),
  .rv_req_i          ({rv_tck_o, rv_tms_o, rv_tdi_o, rv_trst_no}),
  .dft_req_i         ({dft_tck_o, dft_tms_o, dft_tdi_o, dft_trst_no}),
  .dft_strap_valid_i (dft_strap_valid_o)
);

`default_nettype wire

//--- source/pinmux_strap_top.sv
/*
  Strap sampling and JTAG TAP selection top level of the pin multiplexer
*/
`timescale 1ns/1ns
`default_nettype none

module pinmux_strap_top #(
  parameter int unsigned NumIos        = pinmux_cfg_pkg::NumIos,
  parameter bit          ConstSampling = 1'b0
) (
  input  wire logic                       clk_i,
  input  wire logic                       rst_ni,
  input  wire lc_jtag_pkg::lc_tx_t        scanmode_i,
  input  wire lc_jtag_pkg::lc_tx_t        lc_dft_en_i,
  input  wire lc_jtag_pkg::lc_tx_t        lc_hw_debug_en_i,
  input  wire logic                       strap_en_i,
  // Pad ring and core side
  input  wire logic [NumIos-1:0]          in_padring_i,
  input  wire logic [NumIos-1:0]          out_core_i,
  input  wire logic [NumIos-1:0]          oe_core_i,
  output      logic [NumIos-1:0]          out_padring_o,
  output      logic [NumIos-1:0]          oe_padring_o,
  output      logic [NumIos-1:0]          in_core_o,
  // Sampled DFT straps
  output      logic                       dft_strap_valid_o,
  output      pinmux_cfg_pkg::dft_strap_t dft_strap_o,
  // Life-cycle TAP
  output      logic                       lc_tck_o,
  output      logic                       lc_tms_o,
  output      logic                       lc_tdi_o,
  output      logic                       lc_trst_no,
  input  wire logic                       lc_tdo_i,
  input  wire logic                       lc_tdo_oe_i,
  // RISC-V debug TAP
  output      logic                       rv_tck_o,
  output      logic                       rv_tms_o,
  output      logic                       rv_tdi_o,
  output      logic                       rv_trst_no,
  input  wire logic                       rv_tdo_i,
  input  wire logic                       rv_tdo_oe_i,
  // DFT TAP
  output      logic                       dft_tck_o,
  output      logic                       dft_tms_o,
  output      logic                       dft_tdi_o,
  output      logic                       dft_trst_no,
  input  wire logic                       dft_tdo_i,
  input  wire logic                       dft_tdo_oe_i
);

  import lc_jtag_pkg::*;
  import pinmux_cfg_pkg::*;

  lc_tx_t [1:0] lc_hw_debug_en;
  lc_tx_t [1:0] lc_dft_en;
  tap_strap_e   tap_strap;
  logic         scan_en;

  jtag_if lc_jtag_if ();
  jtag_if rv_jtag_if ();
  jtag_if dft_jtag_if ();

  ////////////////////
  // Synchronizers
  ////////////////////

  lc_sync u_lc_sync_hw_debug (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .lc_en_i (lc_hw_debug_en_i),
    .lc_en_o (lc_hw_debug_en)
  );

  lc_sync u_lc_sync_dft (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .lc_en_i (lc_dft_en_i),
    .lc_en_o (lc_dft_en)
  );

  // Scan mode is a static test level and is not synchronized
  assign scan_en = (scanmode_i == lc_on);

  ////////////////////
  // Sampling and mux
  ////////////////////

  strap_sampler #(
    .NumIos        (NumIos),
    .ConstSampling (ConstSampling)
  ) u_strap_sampler (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .strap_en_i        (strap_en_i),
    .in_padring_i      (in_padring_i),
    .lc_dft_en_i       (lc_dft_en[0]),
    .lc_hw_debug_en_i  (lc_hw_debug_en[0]),
    .tap_strap_o       (tap_strap),
    .dft_strap_valid_o (dft_strap_valid_o),
    .dft_strap_o       (dft_strap_o)
  );

  tap_mux #(
    .NumIos (NumIos)
  ) u_tap_mux (
    .tap_strap_i      (tap_strap),
    .lc_dft_en_i      (lc_dft_en[1]),
    .lc_hw_debug_en_i (lc_hw_debug_en[1]),
    .scan_en_i        (scan_en),
    .rst_ni           (rst_ni),
    .in_padring_i     (in_padring_i),
    .out_core_i       (out_core_i),
    .oe_core_i        (oe_core_i),
    .in_core_o        (in_core_o),
    .out_padring_o    (out_padring_o),
    .oe_padring_o     (oe_padring_o),
    .lc_jtag          (lc_jtag_if.host),
    .rv_jtag          (rv_jtag_if.host),
    .dft_jtag         (dft_jtag_if.host)
  );

  ////////////////////
  // TAP side of the links
  ////////////////////

  assign lc_tck_o           = lc_jtag_if.tck;
  assign lc_tms_o           = lc_jtag_if.tms;
  assign lc_tdi_o           = lc_jtag_if.tdi;
  assign lc_trst_no         = lc_jtag_if.trst_n;
  assign lc_jtag_if.tdo     = lc_tdo_i;
  assign lc_jtag_if.tdo_oe  = lc_tdo_oe_i;

  assign rv_tck_o           = rv_jtag_if.tck;
  assign rv_tms_o           = rv_jtag_if.tms;
  assign rv_tdi_o           = rv_jtag_if.tdi;
  assign rv_trst_no         = rv_jtag_if.trst_n;
  assign rv_jtag_if.tdo     = rv_tdo_i;
  assign rv_jtag_if.tdo_oe  = rv_tdo_oe_i;

  assign dft_tck_o          = dft_jtag_if.tck;
  assign dft_tms_o          = dft_jtag_if.tms;
  assign dft_tdi_o          = dft_jtag_if.tdi;
  assign dft_trst_no        = dft_jtag_if.trst_n;
  assign dft_jtag_if.tdo    = dft_tdo_i;
  assign dft_jtag_if.tdo_oe = dft_tdo_oe_i;

endmodule

`default_nettype wire

//--- source/tap_mux.sv
/*
  TAP selection mux: routes the JTAG pads to the strapped TAP under life-cycle
  gating, ties off the core inputs and overrides TDO while a TAP is selected
*/
`timescale 1ns/1ns
`default_nettype none

module tap_mux #(
  parameter int unsigned NumIos = pinmux_cfg_pkg::NumIos
) (
  input  wire pinmux_cfg_pkg::tap_strap_e tap_strap_i,
  input  wire lc_jtag_pkg::lc_tx_t        lc_dft_en_i,
  input  wire lc_jtag_pkg::lc_tx_t        lc_hw_debug_en_i,
  input  wire logic                       scan_en_i,
  input  wire logic                       rst_ni,
  input  wire logic [NumIos-1:0]          in_padring_i,
  input  wire logic [NumIos-1:0]          out_core_i,
  input  wire logic [NumIos-1:0]          oe_core_i,
  output      logic [NumIos-1:0]          in_core_o,
  output      logic [NumIos-1:0]          out_padring_o,
  output      logic [NumIos-1:0]          oe_padring_o,
  jtag_if.host                            lc_jtag,
  jtag_if.host                            rv_jtag,
  jtag_if.host                            dft_jtag
);

  import lc_jtag_pkg::*;
  import pinmux_cfg_pkg::*;

  logic      jtag_en;
  logic      trst_n;
  jtag_req_t jtag_req;
  jtag_req_t lc_req;
  jtag_req_t rv_req;
  jtag_req_t dft_req;
  jtag_rsp_t jtag_rsp;
  jtag_rsp_t lc_rsp;
  jtag_rsp_t rv_rsp;
  jtag_rsp_t dft_rsp;

  ////////////////////
  // Pad request
  ////////////////////

  // Scan mode resets the selected TAP together with the chip
  assign trst_n = scan_en_i ? rst_ni : in_padring_i[TrstIdx];

  assign jtag_req = {in_padring_i[TckIdx], in_padring_i[TmsIdx],
                     in_padring_i[TdiIdx], trst_n};

  ////////////////////
  // TAP select
  ////////////////////

  always_comb begin
    // Unselected TAPs see all zeros and stay in reset
    lc_req   = '0;
    rv_req   = '0;
    dft_req  = '0;
    jtag_rsp = '0;
    jtag_en  = 1'b0;
    case (tap_strap_i)
      LcTapSel: begin
        lc_req   = jtag_req;
        jtag_rsp = lc_rsp;
        jtag_en  = 1'b1;
      end
      RvTapSel: begin
        if (lc_hw_debug_en_i == lc_on) begin
          rv_req   = jtag_req;
          jtag_rsp = rv_rsp;
          jtag_en  = 1'b1;
        end
      end
      DftTapSel: begin
        if (lc_dft_en_i == lc_on) begin
          dft_req  = jtag_req;
          jtag_rsp = dft_rsp;
          jtag_en  = 1'b1;
        end
      end
      default: begin
        jtag_en = 1'b0;
      end
    endcase
  end

  // Unpack into the three links
  assign {lc_jtag.tck, lc_jtag.tms, lc_jtag.tdi, lc_jtag.trst_n}     = lc_req;
  assign {rv_jtag.tck, rv_jtag.tms, rv_jtag.tdi, rv_jtag.trst_n}     = rv_req;
  assign {dft_jtag.tck, dft_jtag.tms, dft_jtag.tdi, dft_jtag.trst_n} = dft_req;

  assign lc_rsp  = {lc_jtag.tdo, lc_jtag.tdo_oe};
  assign rv_rsp  = {rv_jtag.tdo, rv_jtag.tdo_oe};
  assign dft_rsp = {dft_jtag.tdo, dft_jtag.tdo_oe};

  ////////////////////
  // Pad muxing
  ////////////////////

  for (genvar k = 0; k < NumIos; k++) begin : gen_pad
    if (k == TckIdx || k == TmsIdx || k == TrstIdx ||
        k == TdiIdx || k == TdoIdx) begin : gen_jtag_in
      assign in_core_o[k] = jtag_en ? JtagTieOffs[k] : in_padring_i[k];
    end else begin : gen_other_in
      assign in_core_o[k] = in_padring_i[k];
    end

    if (k == TdoIdx) begin : gen_tdo
      // jtag_rsp is {tdo, tdo_oe}
      assign out_padring_o[k] = jtag_en ? jtag_rsp[1] : out_core_i[k];
      assign oe_padring_o[k]  = jtag_en ? jtag_rsp[0] : oe_core_i[k];
    end else begin : gen_other_out
      assign out_padring_o[k] = out_core_i[k];
      assign oe_padring_o[k]  = oe_core_i[k];
    end
  end

endmodule

`default_nettype wire

//--- source/strap_sampler.sv
/*
  Strap sampler: loads TAP and DFT straps from the pads, qualified by life cycle,
  and keeps sampling in DFT mode when the first sample is not functional
*/
`timescale 1ns/1ns
`default_nettype none

module strap_sampler #(
  parameter int unsigned NumIos        = pinmux_cfg_pkg::NumIos,
  parameter bit          ConstSampling = 1'b0
) (
  input  wire logic                      clk_i,
  input  wire logic                      rst_ni,
  input  wire logic                      strap_en_i,
  input  wire logic [NumIos-1:0]         in_padring_i,
  input  wire lc_jtag_pkg::lc_tx_t       lc_dft_en_i,
  input  wire lc_jtag_pkg::lc_tx_t       lc_hw_debug_en_i,
  output      pinmux_cfg_pkg::tap_strap_e tap_strap_o,
  output      logic                      dft_strap_valid_o,
  output      pinmux_cfg_pkg::dft_strap_t dft_strap_o
);

  import lc_jtag_pkg::*;
  import pinmux_cfg_pkg::*;

  logic                  strap_en_q;
  logic                  cont_sampling_d;
  logic                  cont_sampling_q;
  logic                  sample_en;
  logic                  rv_sample_en;
  logic                  dft_sample_en;
  logic [NTapStraps-1:0] tap_strap_d;
  logic [NTapStraps-1:0] tap_strap_q;
  dft_strap_t            dft_strap_d;
  dft_strap_t            dft_strap_q;
  logic                  dft_strap_valid_q;

  ////////////////////
  // Sample enables
  ////////////////////

  // One pulse from the power manager, or every cycle once continuous
  assign sample_en     = strap_en_i | cont_sampling_q;
  assign rv_sample_en  = sample_en & (lc_hw_debug_en_i == lc_on);
  assign dft_sample_en = sample_en & (lc_dft_en_i == lc_on);

  // TAP strap 0 is always taken, strap 1 only with hardware debug
  assign tap_strap_d[0] = sample_en    ? in_padring_i[TapStrap0Idx] : tap_strap_q[0];
  assign tap_strap_d[1] = rv_sample_en ? in_padring_i[TapStrap1Idx] : tap_strap_q[1];

  assign dft_strap_d = dft_sample_en ?
                       {in_padring_i[DftStrap1Idx], in_padring_i[DftStrap0Idx]} :
                       dft_strap_q;

  ////////////////////
  // Continue sampling
  ////////////////////

  always_comb begin
    cont_sampling_d = cont_sampling_q;
    // Non-functional first sample in a DFT state keeps the straps live
    if ((lc_dft_en_i == lc_on) && strap_en_q &&
        (tap_strap_e'(tap_strap_q) != FuncSel)) begin
      cont_sampling_d = 1'b1;
    end
    if (ConstSampling) begin
      cont_sampling_d = 1'b1;
    end
  end

  ////////////////////
  // Registers
  ////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      tap_strap_q       <= '0;
      dft_strap_q       <= '0;
      strap_en_q        <= 1'b0;
      dft_strap_valid_q <= 1'b0;
      cont_sampling_q   <= 1'b0;
    end else begin
      tap_strap_q       <= tap_strap_d;
      dft_strap_q       <= dft_strap_d;
      strap_en_q        <= strap_en_i;
      // Sticky until reset
      dft_strap_valid_q <= dft_strap_valid_q | dft_sample_en;
      cont_sampling_q   <= cont_sampling_d;
    end
  end

  assign tap_strap_o       = tap_strap_e'(tap_strap_q);
  assign dft_strap_o       = dft_strap_q;
  assign dft_strap_valid_o = dft_strap_valid_q;

endmodule

`default_nettype wire

//--- source/lc_sync.sv
/*
  Two-flop synchronizer for a life-cycle enable with two output copies
*/
`timescale 1ns/1ns
`default_nettype none

module lc_sync (
  input  wire logic                       clk_i,
  input  wire logic                       rst_ni,
  input  wire lc_jtag_pkg::lc_tx_t        lc_en_i,
  output      lc_jtag_pkg::lc_tx_t [1:0]  lc_en_o
);

  import lc_jtag_pkg::*;

  lc_tx_t sync_q1;
  lc_tx_t sync_q2;

  // Each bit is synchronized on its own, reset value is the Off pattern
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      sync_q1 <= lc_off;
      sync_q2 <= lc_off;
    end else begin
      sync_q1 <= lc_en_i;
      sync_q2 <= sync_q1;
    end
  end

  // Copy 0 feeds strap sampling, copy 1 feeds TAP muxing
  assign lc_en_o[0] = sync_q2;
  assign lc_en_o[1] = sync_q2;

endmodule

`default_nettype wire

//--- source/jtag_if.sv
/*
  JTAG link to one TAP, request toward the TAP and response back
*/
`timescale 1ns/1ns
`default_nettype none

interface jtag_if;

  // Request side
  logic tck;
  logic tms;
  logic tdi;
  logic trst_n;

  // Response side
  logic tdo;
  logic tdo_oe;

  // Pad mux end of the link
  modport host (
    output tck, tms, tdi, trst_n,
    input  tdo, tdo_oe
  );

  // TAP end of the link
  modport device (
    input  tck, tms, tdi, trst_n,
    output tdo, tdo_oe
  );

endinterface

`default_nettype wire

//--- source/pinmux_cfg_pkg.sv
/*
  Pad mapping, JTAG tie-offs and strap encoding of the pad ring
*/
`default_nettype none

package pinmux_cfg_pkg;

  ////////////////////
  // Pad mapping
  ////////////////////

  localparam int unsigned NumIos = 16;

  // JTAG pins
  localparam int unsigned TckIdx  = 0;
  localparam int unsigned TmsIdx  = 1;
  localparam int unsigned TrstIdx = 2;
  localparam int unsigned TdiIdx  = 3;
  localparam int unsigned TdoIdx  = 4;

  // Strap pins
  localparam int unsigned TapStrap0Idx = 5;
  localparam int unsigned TapStrap1Idx = 6;
  localparam int unsigned DftStrap0Idx = 7;
  localparam int unsigned DftStrap1Idx = 8;

  // Core-side values of the JTAG pads while a TAP owns them.
  // TMS and TRST read high, the rest low
  localparam logic [15:0] JtagTieOffs = 16'h0006;

  ////////////////////
  // Straps
  ////////////////////

  localparam int unsigned NTapStraps = 2;
  localparam int unsigned NDftStraps = 2;

  typedef enum logic [NTapStraps-1:0] {
    FuncSel   = 2'd0,
    LcTapSel  = 2'd1,
    RvTapSel  = 2'd2,
    DftTapSel = 2'd3
  } tap_strap_e;

  typedef logic [NDftStraps-1:0] dft_strap_t;

endpackage

`default_nettype wire

//--- source/lc_jtag_pkg.sv
/*
  Life-cycle enable encoding and JTAG request and response widths
*/
`default_nettype none

package lc_jtag_pkg;

  ////////////////////
  // Life cycle
  ////////////////////

  // Multi-bit enable, only the On pattern counts as enabled
  typedef logic [3:0] lc_tx_t;

  localparam lc_tx_t lc_on  = 4'b1010;
  localparam lc_tx_t lc_off = 4'b0101;

  ////////////////////
  // JTAG
  ////////////////////

  // Request is {tck, tms, tdi, trst_n}
  localparam int unsigned JtagReqWidth = 4;
  // Response is {tdo, tdo_oe}
  localparam int unsigned JtagRspWidth = 2;

  typedef logic [JtagReqWidth-1:0] jtag_req_t;
  typedef logic [JtagRspWidth-1:0] jtag_rsp_t;

endpackage

`default_nettype wire
